//--- tb.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/deReg.sv
hdl/execUnit.sv
hdl/decodeExecCore.sv
verif/coreChecks_sva.sv
verif/coreTb.sv

//--- verif/coreTb.sv
`timescale 1ns/1ps

module coreTb
    import isaPkg::*;
;

    localparam int maxWait = 20;

    logic        CLK;
    logic        Reset;
    logic [31:0] Instr;
    logic        FlushE;
    logic        WE3;
    logic [3:0]  WA3;
    logic [31:0] WD3;
    logic [31:0] ALUResult;
    logic [31:0] WriteData;
    logic [3:0]  WA3E;
    logic        RegWriteE;
    logic        MemWriteE;
    logic        MemtoRegE;
    logic [3:0]  Flags;

    logic [31:0] shadowRegs [16];  // entry 15 is never written and reads 0
    logic [3:0]  shadowFlags;
    logic [31:0] expAlu, nxtAlu, expData, nxtData;  // exp is in execute and nxt in decode
    logic [3:0]  expWa, nxtWa, expFlags, nxtFlags;
    logic        expRw, nxtRw, expMw, nxtMw, expM2r, nxtM2r, expValid, nxtValid;
    logic [36:0] wbQ [$];  // {write enable, address, data} waiting for write-back
    logic [36:0] wb;
    int          testErrs, totalErrs, testCount;

    decodeExecCore decodeExecCore_i (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic condPass(logic [3:0] cond, logic [3:0] f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cond)
            condEQ: return z;
            condNE: return !z;
            condCS: return c;
            condCC: return !c;
            condMI: return n;
            condPL: return !n;
            condVS: return v;
            condVC: return !v;
            condHI: return c && !z;
            condLS: return !c || z;
            condGE: return n == v;
            condLT: return n != v;
            condGT: return !z && (n == v);
            condLE: return z || (n != v);
            default: return cond == condAL;
        endcase
    endfunction

    function automatic instrWord_u dpInstr(logic [3:0] cond, logic [3:0] cmd, logic i, logic s,
                                           logic [3:0] rn, logic [3:0] rd, logic [11:0] src2);
        instrWord_u ins;
        ins.dp = '{cond, opDataProc, i, cmd, s, rn, rd, src2};
        return ins;
    endfunction

    function automatic instrWord_u memInstr(logic [3:0] cond, logic u, logic l, logic [3:0] rn,
                                            logic [3:0] rd, logic [11:0] imm12);
        instrWord_u ins;
        ins.mem = '{cond, opMemory, 1'b0, 1'b1, u, 1'b0, 1'b0, l, rn, rd, imm12};
        return ins;
    endfunction

    function automatic instrWord_u randInstr();
        logic [3:0]  cmdList [5];
        logic [11:0] src2;
        logic        imm;
        cmdList = '{cmdAdd, cmdSub, cmdAnd, cmdOrr, cmdCmp};
        src2 = 12'($urandom);
        imm = 1'($urandom);
        if ($urandom_range(3) == 0)
            return memInstr(4'($urandom_range(14)), 1'($urandom), 1'($urandom),
                            4'($urandom), 4'($urandom), src2);
        if (!imm) src2[4] = 1'b0;  // shift by immediate form
        return dpInstr(4'($urandom_range(14)), cmdList[$urandom_range(4)], imm, 1'($urandom),
                       4'($urandom), 4'($urandom), src2);
    endfunction

    // ######################################################################
    // reference model of the slot entering execute
    // ######################################################################
    function automatic void predict(instrWord_u ins, logic flush);
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] sum;
        logic [63:0] rot;
        logic        pass;
        logic        c;
        logic        v;
        nxtFlags = shadowFlags;
        {nxtAlu, nxtData, nxtWa, nxtRw, nxtMw, nxtM2r} = '0;
        if (flush) return;
        a = shadowRegs[ins.dp.Rn];  // Rn sits at the same bits in both views
        pass = condPass(ins.dp.cond, shadowFlags);
        if (ins.dp.op == opMemory) begin
            b = {20'b0, ins.mem.imm12};
            nxtAlu = ins.mem.U ? a + b : a - b;
            nxtData = shadowRegs[ins.mem.Rd];
            nxtWa = ins.mem.Rd;
            nxtRw = pass && ins.mem.L;
            nxtM2r = pass && ins.mem.L;
            nxtMw = pass && !ins.mem.L;
            return;
        end
        nxtData = shadowRegs[ins.dp.src2[3:0]];
        nxtWa = ins.dp.Rd;
        rot = {nxtData, nxtData} >> ins.dp.src2[11:7];
        if (ins.dp.I) b = {24'b0, ins.dp.src2[7:0]};
        else case (ins.dp.src2[6:5])
            shLsl:   b = nxtData << ins.dp.src2[11:7];
            shLsr:   b = nxtData >> ins.dp.src2[11:7];
            shAsr:   b = $signed(nxtData) >>> ins.dp.src2[11:7];
            default: b = rot[31:0];
        endcase
        {c, v} = shadowFlags[1:0];
        case (ins.dp.cmd)
            cmdAnd: nxtAlu = a & b;
            cmdOrr: nxtAlu = a | b;
            cmdAdd: begin
                sum = {1'b0, a} + {1'b0, b};
                nxtAlu = sum[31:0];
                c = sum[32];
                v = (a[31] == b[31]) && (nxtAlu[31] != a[31]);
            end
            default: begin  // SUB and CMP take carry as the inverted borrow
                sum = {1'b0, a} - {1'b0, b};
                nxtAlu = sum[31:0];
                c = !sum[32];
                v = (a[31] != b[31]) && (nxtAlu[31] != a[31]);
            end
        endcase
        nxtRw = pass && (ins.dp.cmd != cmdCmp);
        if (pass && ins.dp.S) begin
            shadowFlags[3:2] = {nxtAlu[31], nxtAlu == 32'b0};
            if (ins.dp.cmd inside {cmdAdd, cmdSub, cmdCmp}) shadowFlags[1:0] = {c, v};
        end
    endfunction

    task automatic issue(instrWord_u ins, logic flush, logic we, logic [3:0] wa, logic [31:0] wd);
        @(posedge CLK);
        {expAlu, expData, expWa, expRw, expMw, expM2r, expFlags, expValid} =
            {nxtAlu, nxtData, nxtWa, nxtRw, nxtMw, nxtM2r, nxtFlags, nxtValid};
        Instr  <= ins;
        FlushE <= flush;
        WE3    <= we;
        WA3    <= wa;
        WD3    <= wd;
        predict(ins, flush);
        nxtValid = 1'b1;
        if (we && wa != 4'hF) shadowRegs[wa] = wd;  // visible to reads from the next cycle on
    endtask

    task automatic checkVal(string name, logic [31:0] act, logic [31:0] exp);
        assert (act === exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            testErrs++;
        end
    endtask

    always @(negedge CLK) begin
        if (expValid) begin
            checkVal("ALUResult", ALUResult, expAlu);
            checkVal("WriteData", WriteData, expData);
            checkVal("WA3E", 32'(WA3E), 32'(expWa));
            checkVal("RegWriteE", 32'(RegWriteE), 32'(expRw));
            checkVal("MemWriteE", 32'(MemWriteE), 32'(expMw));
            checkVal("MemtoRegE", 32'(MemtoRegE), 32'(expM2r));
            checkVal("Flags", 32'(Flags), 32'(expFlags));
        end
    end

    task automatic endTest(string name);
        issue('0, 1'b1, 1'b0, 4'h0, 32'h0);
        @(negedge CLK);
        #1;  // the output checks of this edge are counted first
        $display("%s: %0d errors", name, testErrs);
        totalErrs += testErrs;
        testErrs = 0;
        testCount++;
    endtask

    task automatic waitResetIdle(output logic idle);
        int tries;
        tries = 0;
        while ((RegWriteE !== 1'b0 || MemWriteE !== 1'b0 || MemtoRegE !== 1'b0
                || Flags !== 4'h0) && tries < maxWait) begin
            @(negedge CLK);
            tries++;
        end
        idle = (tries < maxWait);
    endtask

    task automatic runTests();
        logic [3:0] dpCmds [4];
        dpCmds = '{cmdAdd, cmdSub, cmdAnd, cmdOrr};

        issue(dpInstr(condAL, cmdAdd, 1'b1, 1'b1, 4'h1, 4'h2, 12'h005), 1'b1, 1'b0, 4'h0, 32'h0);
        issue(memInstr(condAL, 1'b1, 1'b0, 4'h3, 4'h4, 12'h010), 1'b1, 1'b0, 4'h0, 32'h0);
        issue(dpInstr(condAL, cmdAdd, 1'b1, 1'b0, 4'h1, 4'h2, 12'h005), 1'b0, 1'b0, 4'h0, 32'h0);
        endTest("reset and flush");

        for (int r = 0; r < 15; r++) issue('0, 1'b1, 1'b1, 4'(r), $urandom);
        for (int r = 0; r < 16; r++) begin
            issue(dpInstr(condAL, cmdAdd, 1'b1, 1'b0, 4'(r), 4'($urandom), 12'($urandom_range(255))),
                  1'b0, 1'b0, 4'h0, 32'h0);
            issue(dpInstr(condAL, cmdOrr, 1'b1, 1'b0, 4'(r), 4'($urandom), 12'($urandom_range(255))),
                  1'b0, 1'b0, 4'h0, 32'h0);
        end
        endTest("register write and read");

        for (int k = 0; k < 40; k++) begin
            issue(dpInstr(condAL, dpCmds[k % 4], 1'b0, 1'b0, 4'($urandom), 4'($urandom),
                          {5'($urandom), 2'(k / 4), 1'b0, 4'($urandom)}), 1'b0, 1'b0, 4'h0, 32'h0);
        end
        endTest("shifted register operand");

        for (int k = 0; k < 12; k++) begin
            wb[3:0] = 4'($urandom_range(14));
            issue(dpInstr(condAL, (k % 3 == 0) ? cmdCmp : ((k % 3 == 1) ? cmdAdd : cmdSub), 1'b0,
                          1'b1, wb[3:0], 4'($urandom), {8'h0, (k % 2) ? wb[3:0] : 4'($urandom)}),
                  1'b0, 1'b0, 4'h0, 32'h0);
            for (int c = 0; c < 15; c++) begin
                issue(dpInstr(4'(c), cmdAdd, 1'b1, 1'b0, 4'($urandom), 4'($urandom), 12'h001),
                      1'b0, 1'b0, 4'h0, 32'h0);
            end
        end
        endTest("flags and conditions");

        for (int k = 0; k < 20; k++) begin
            issue(memInstr(condAL, 1'($urandom), 1'($urandom), 4'($urandom), 4'($urandom),
                           12'($urandom)), 1'b0, 1'b0, 4'h0, 32'h0);
        end
        endTest("load and store");

        wbQ.delete();
        for (int k = 0; k < 60; k++) begin
            wb = (wbQ.size() == 2) ? wbQ.pop_front() : '0;
            issue(randInstr(), 1'b0, wb[36], wb[35:32], wb[31:0]);
            wbQ.push_back({nxtRw, nxtWa, nxtAlu});  // memory returns the address on a load
        end
        endTest("random stream");
    endtask

    initial begin
        logic idle;
        void'($urandom(32'h54ae));
        {Reset, Instr, FlushE, WE3, WA3, WD3} = {1'b1, 32'h0, 1'b0, 1'b0, 4'h0, 32'h0};
        foreach (shadowRegs[i]) shadowRegs[i] = '0;
        shadowFlags = '0;
        {nxtAlu, nxtData, nxtWa, nxtRw, nxtMw, nxtM2r, nxtFlags, nxtValid, expValid} = '0;
        {testErrs, totalErrs, testCount} = '0;
        repeat (5) @(posedge CLK);
        Reset <= 1'b0;
        waitResetIdle(idle);

        if (idle) begin
            runTests();
        end else begin
            $display("timeout: write outputs and Flags did not clear after reset");
            totalErrs++;
        end

        $display("%0d tests, %0d errors", testCount, totalErrs);
        if (totalErrs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/coreChecks_sva.sv
`timescale 1ns/1ps

module coreChecks_sva
    import isaPkg::*;
(
    input logic       CLK,
    input logic       Reset,
    input logic       FlushE,
    input instrWord_u Instr,
    input logic       RegWriteE,
    input logic       MemWriteE,
    input logic       MemtoRegE
);

    // ######################################################################
    // an empty slot after reset or flush writes nothing
    // ######################################################################
    emptyAfterReset: assert property (
        @(posedge CLK) $fell(Reset) |-> !RegWriteE && !MemWriteE && !MemtoRegE
    ) else $error("write output high in the first cycle after reset");

    emptyAfterFlush: assert property (
        @(posedge CLK) disable iff (Reset)
        FlushE |=> !RegWriteE && !MemWriteE && !MemtoRegE
    ) else $error("write output high in a flushed slot");

    // a slot is a register write or a memory write but never both
    exclusiveWrites: assert property (
        @(posedge CLK) disable iff (Reset) !(RegWriteE && MemWriteE)
    ) else $error("RegWriteE and MemWriteE high together");

    // a compare leaving decode has no register write in its execute cycle
    cmpNoRegWrite: assert property (
        @(posedge CLK) disable iff (Reset)
        (Instr.dp.op == opDataProc) && (Instr.dp.cmd == cmdCmp) |=> !RegWriteE
    ) else $error("compare in execute raised RegWriteE");

endmodule

bind decodeExecCore coreChecks_sva checks_i (
    .CLK(CLK),
    .Reset(Reset),
    .FlushE(FlushE),
    .Instr(Instr),
    .RegWriteE(RegWriteE),
    .MemWriteE(MemWriteE),
    .MemtoRegE(MemtoRegE)
);

//--- hdl/decodeExecCore.sv
`timescale 1ns/1ps

module decodeExecCore
    import pipePkg::*;
(
    input  logic                CLK,
    input  logic                Reset,
    input  logic [31:0]         Instr,
    input  logic                FlushE,
    input  logic                WE3,
    input  logic [regAddrW-1:0] WA3,
    input  logic [31:0]         WD3,
    output logic [31:0]         ALUResult,
    output logic [31:0]         WriteData,
    output logic [regAddrW-1:0] WA3E,
    output logic                RegWriteE,
    output logic                MemWriteE,
    output logic                MemtoRegE,
    output logic [3:0]          Flags
);

    // decode stage
    logic [3:0]          condD;
    logic [1:0]          flagWD;
    logic                regWD;
    logic                memWD;
    logic                memtoRegD;
    logic                aluSrcD;
    logic [1:0]          aluControlD;
    logic [regAddrW-1:0] wa3D;
    logic [regAddrW-1:0] ra1D;
    logic [regAddrW-1:0] ra2D;
    logic [31:0]         rd1D;
    logic [31:0]         rd2D;
    logic [31:0]         extImmD;
    logic [1:0]          shD;
    logic [4:0]          shamt5D;
    logic                noWriteD;

    // execute stage, as latched by deReg
    logic [3:0]          condE;
    logic [1:0]          flagWE;
    logic                regWE;
    logic                memWE;
    logic                memtoRegLatE;
    logic                aluSrcE;
    logic [1:0]          aluControlE;
    logic [regAddrW-1:0] wa3LatE;
    logic [regAddrW-1:0] ra1E;
    logic [regAddrW-1:0] ra2E;
    logic [31:0]         rd1E;
    logic [31:0]         rd2E;
    logic [31:0]         extImmE;
    logic [1:0]          shE;
    logic [4:0]          shamt5E;
    logic                noWriteE;

    instrDecoder instrDecoder_i (
        .Instr(Instr), .CondD(condD), .FlagWD(flagWD), .RegWD(regWD), .MemWD(memWD),
        .MemtoRegD(memtoRegD), .ALUSrcD(aluSrcD), .ALUControlD(aluControlD),
        .WA3D(wa3D), .RA1D(ra1D), .RA2D(ra2D), .ExtImmD(extImmD), .ShD(shD),
        .Shamt5D(shamt5D), .NoWriteD(noWriteD)
    );

    regFile regFile_i (
        .CLK(CLK), .Reset(Reset), .WE3(WE3), .A1(ra1D), .A2(ra2D), .A3(WA3),
        .WD3(WD3), .RD1(rd1D), .RD2(rd2D)
    );

    deReg deReg_i (
        .CLK(CLK), .Reset(Reset), .Flush(FlushE),
        .CondD(condD), .FlagWD(flagWD), .RegWD(regWD), .MemWD(memWD),
        .MemtoRegD(memtoRegD), .ALUSrcD(aluSrcD), .ALUControlD(aluControlD),
        .WA3D(wa3D), .RA1D(ra1D), .RA2D(ra2D), .RD1D(rd1D), .RD2D(rd2D),
        .ExtImmD(extImmD), .ShD(shD), .Shamt5D(shamt5D), .NoWriteD(noWriteD),
        .CondE(condE), .FlagWE(flagWE), .RegWE(regWE), .MemWE(memWE),
        .MemtoRegE(memtoRegLatE), .ALUSrcE(aluSrcE), .ALUControlE(aluControlE),
        .WA3E(wa3LatE), .RA1E(ra1E), .RA2E(ra2E), .RD1E(rd1E), .RD2E(rd2E),
        .ExtImmE(extImmE), .ShE(shE), .Shamt5E(shamt5E), .NoWriteE(noWriteE)
    );

    execUnit execUnit_i (
        .CLK(CLK), .Reset(Reset),
        .CondE(condE), .FlagWE(flagWE), .RegWE(regWE), .MemWE(memWE),
        .MemtoRegE(memtoRegLatE), .ALUSrcE(aluSrcE), .ALUControlE(aluControlE),
        .WA3E(wa3LatE), .RD1E(rd1E), .RD2E(rd2E), .ExtImmE(extImmE), .ShE(shE),
        .Shamt5E(shamt5E), .NoWriteE(noWriteE),
        .ALUResult(ALUResult), .WriteData(WriteData), .WA3(WA3E),
        .RegWrite(RegWriteE), .MemWrite(MemWriteE), .MemtoReg(MemtoRegE), .Flags(Flags)
    );

endmodule

//--- hdl/execUnit.sv
`timescale 1ns/1ps

module execUnit
    import isaPkg::*, pipePkg::*;
(
    input  logic                CLK,
    input  logic                Reset,
    input  logic [3:0]          CondE,
    input  logic [1:0]          FlagWE,
    input  logic                RegWE,
    input  logic                MemWE,
    input  logic                MemtoRegE,
    input  logic                ALUSrcE,
    input  logic [1:0]          ALUControlE,
    input  logic [regAddrW-1:0] WA3E,
    input  logic [31:0]         RD1E,
    input  logic [31:0]         RD2E,
    input  logic [31:0]         ExtImmE,
    input  logic [1:0]          ShE,
    input  logic [4:0]          Shamt5E,
    input  logic                NoWriteE,
    output logic [31:0]         ALUResult,
    output logic [31:0]         WriteData,
    output logic [regAddrW-1:0] WA3,
    output logic                RegWrite,
    output logic                MemWrite,
    output logic                MemtoReg,
    output logic [3:0]          Flags
);

    logic [31:0] shiftOut;
    logic [31:0] srcB;
    logic        aluC;
    logic        aluV;
    logic        flagN;
    logic        flagZ;
    logic        flagC;
    logic        flagV;
    logic        condEx;

    // ####################################################################
    // shifter and ALU
    // ####################################################################
    always_comb begin
        case (ShE)
            shLsl:   shiftOut = RD2E << Shamt5E;
            shLsr:   shiftOut = RD2E >> Shamt5E;
            shAsr:   shiftOut = $signed(RD2E) >>> Shamt5E;
            default: shiftOut = (RD2E >> Shamt5E) | (RD2E << (6'd32 - {1'b0, Shamt5E}));
        endcase
    end

    assign srcB = ALUSrcE ? ExtImmE : shiftOut;

    always_comb begin
        aluC = 1'b0;
        aluV = 1'b0;
        case (ALUControlE)
            aluAdd: begin
                {aluC, ALUResult} = {1'b0, RD1E} + {1'b0, srcB};
                aluV = (RD1E[31] == srcB[31]) && (ALUResult[31] != RD1E[31]);
            end
            aluSub: begin
                {aluC, ALUResult} = {1'b0, RD1E} + {1'b0, ~srcB} + 33'd1;  // C is not-borrow
                aluV = (RD1E[31] != srcB[31]) && (ALUResult[31] != RD1E[31]);
            end
            aluAnd:  ALUResult = RD1E & srcB;
            default: ALUResult = RD1E | srcB;
        endcase
    end

    // ####################################################################
    // condition check and flags register
    // ####################################################################
    assign {flagN, flagZ, flagC, flagV} = Flags;

    always_comb begin
        case (CondE)
            condEQ:  condEx = flagZ;
            condNE:  condEx = ~flagZ;
            condCS:  condEx = flagC;
            condCC:  condEx = ~flagC;
            condMI:  condEx = flagN;
            condPL:  condEx = ~flagN;
            condVS:  condEx = flagV;
            condVC:  condEx = ~flagV;
            condHI:  condEx = flagC & ~flagZ;
            condLS:  condEx = ~flagC | flagZ;
            condGE:  condEx = (flagN == flagV);
            condLT:  condEx = (flagN != flagV);
            condGT:  condEx = ~flagZ & (flagN == flagV);
            condLE:  condEx = flagZ | (flagN != flagV);
            condAL:  condEx = 1'b1;
            default: condEx = 1'b0;
        endcase
    end

    always_ff @(posedge CLK, posedge Reset) begin
        if (Reset) begin
            Flags <= '0;
        end else if (condEx) begin
            if (FlagWE[1]) Flags[3:2] <= {ALUResult[31], ALUResult == 32'b0};
            if (FlagWE[0]) Flags[1:0] <= {aluC, aluV};
        end
    end

    assign RegWrite  = condEx & RegWE & ~NoWriteE;
    assign MemWrite  = condEx & MemWE;
    assign MemtoReg  = condEx & MemtoRegE;
    assign WriteData = RD2E;
    assign WA3       = WA3E;

endmodule

//--- hdl/deReg.sv
`timescale 1ns/1ps

module deReg
    import pipePkg::*;
(
    input  logic                CLK,
    input  logic                Reset,
    input  logic                Flush,
    input  logic [3:0]          CondD,
    input  logic [1:0]          FlagWD,
    input  logic                RegWD,
    input  logic                MemWD,
    input  logic                MemtoRegD,
    input  logic                ALUSrcD,
    input  logic [1:0]          ALUControlD,
    input  logic [regAddrW-1:0] WA3D,
    input  logic [regAddrW-1:0] RA1D,
    input  logic [regAddrW-1:0] RA2D,
    input  logic [31:0]         RD1D,
    input  logic [31:0]         RD2D,
    input  logic [31:0]         ExtImmD,
    input  logic [1:0]          ShD,
    input  logic [4:0]          Shamt5D,
    input  logic                NoWriteD,
    output logic [3:0]          CondE,
    output logic [1:0]          FlagWE,
    output logic                RegWE,
    output logic                MemWE,
    output logic                MemtoRegE,
    output logic                ALUSrcE,
    output logic [1:0]          ALUControlE,
    output logic [regAddrW-1:0] WA3E,
    output logic [regAddrW-1:0] RA1E,
    output logic [regAddrW-1:0] RA2E,
    output logic [31:0]         RD1E,
    output logic [31:0]         RD2E,
    output logic [31:0]         ExtImmE,
    output logic [1:0]          ShE,
    output logic [4:0]          Shamt5E,
    output logic                NoWriteE
);

    always_ff @(posedge CLK, posedge Reset) begin
        if (Reset) begin
            {CondE, FlagWE, RegWE, MemWE, MemtoRegE, ALUSrcE, ALUControlE, WA3E, RA1E,
             RA2E, RD1E, RD2E, ExtImmE, ShE, Shamt5E, NoWriteE} <= '0;
        end else if (Flush) begin  // a flushed slot looks exactly like the reset slot
            {CondE, FlagWE, RegWE, MemWE, MemtoRegE, ALUSrcE, ALUControlE, WA3E, RA1E,
             RA2E, RD1E, RD2E, ExtImmE, ShE, Shamt5E, NoWriteE} <= '0;
        end else begin
            CondE       <= CondD;
            FlagWE      <= FlagWD;
            RegWE       <= RegWD;
            MemWE       <= MemWD;
            MemtoRegE   <= MemtoRegD;
            ALUSrcE     <= ALUSrcD;
            ALUControlE <= ALUControlD;
            WA3E        <= WA3D;
            RA1E        <= RA1D;  // the read addresses are kept for forwarding
            RA2E        <= RA2D;
            RD1E        <= RD1D;
            RD2E        <= RD2D;
            ExtImmE     <= ExtImmD;
            ShE         <= ShD;
            Shamt5E     <= Shamt5D;
            NoWriteE    <= NoWriteD;
        end
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile
    import pipePkg::*;
(
    input  logic                CLK,
    input  logic                Reset,
    input  logic                WE3,
    input  logic [regAddrW-1:0] A1,
    input  logic [regAddrW-1:0] A2,
    input  logic [regAddrW-1:0] A3,
    input  logic [31:0]         WD3,
    output logic [31:0]         RD1,
    output logic [31:0]         RD2
);

    logic [31:0] regs [numRegs];

    always_ff @(posedge CLK, posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (WE3 && (A3 < numRegs)) begin
            regs[A3] <= WD3;
        end
    end

    // no write bypass, a same-cycle read sees the old value
    assign RD1 = (A1 < numRegs) ? regs[A1] : '0;
    assign RD2 = (A2 < numRegs) ? regs[A2] : '0;

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
    import isaPkg::*, pipePkg::*;
(
    input  instrWord_u             Instr,
    output logic [3:0]             CondD,
    output logic [1:0]             FlagWD,
    output logic                   RegWD,
    output logic                   MemWD,
    output logic                   MemtoRegD,
    output logic                   ALUSrcD,
    output logic [1:0]             ALUControlD,
    output logic [regAddrW-1:0]    WA3D,
    output logic [regAddrW-1:0]    RA1D,
    output logic [regAddrW-1:0]    RA2D,
    output logic [31:0]            ExtImmD,
    output logic [1:0]             ShD,
    output logic [4:0]             Shamt5D,
    output logic                   NoWriteD
);

    logic cmdOk;  // cmd is one of the supported data processing ops

    always_comb begin
        CondD       = Instr.dp.cond;
        FlagWD      = 2'b00;
        RegWD       = 1'b0;
        MemWD       = 1'b0;
        MemtoRegD   = 1'b0;
        ALUSrcD     = 1'b0;
        ALUControlD = aluAdd;
        WA3D        = Instr.dp.Rd;
        RA1D        = Instr.dp.Rn;
        RA2D        = Instr.dp.src2[3:0];
        ExtImmD     = '0;
        ShD         = shLsl;
        Shamt5D     = '0;
        NoWriteD    = 1'b0;
        cmdOk       = 1'b1;

        case (Instr.dp.op)
            opDataProc: begin
                ALUSrcD = Instr.dp.I;
                ExtImmD = {24'b0, Instr.dp.src2[7:0]};  // zero extended, no rotation
                if (!Instr.dp.I) begin
                    ShD     = Instr.dp.src2[6:5];
                    Shamt5D = Instr.dp.src2[11:7];
                end
                case (Instr.dp.cmd)
                    cmdAdd: ALUControlD = aluAdd;
                    cmdSub: ALUControlD = aluSub;
                    cmdAnd: ALUControlD = aluAnd;
                    cmdOrr: ALUControlD = aluOrr;
                    cmdCmp: begin
                        ALUControlD = aluSub;
                        NoWriteD    = 1'b1;  // compare only sets flags
                    end
                    default: cmdOk = 1'b0;
                endcase
                RegWD     = cmdOk;
                FlagWD[1] = cmdOk & Instr.dp.S;  // NZ
                FlagWD[0] = cmdOk & Instr.dp.S
                            & ((ALUControlD == aluAdd) | (ALUControlD == aluSub));  // CV
            end
            opMemory: begin
                ALUSrcD     = 1'b1;
                ALUControlD = Instr.mem.U ? aluAdd : aluSub;
                ExtImmD     = {20'b0, Instr.mem.imm12};
                RA1D        = Instr.mem.Rn;
                RA2D        = Instr.mem.Rd;  // store data comes from Rd
                WA3D        = Instr.mem.Rd;
                RegWD       = Instr.mem.L;
                MemtoRegD   = Instr.mem.L;
                MemWD       = ~Instr.mem.L;
            end
            default: ;  // branches and the rest write nothing
        endcase
    end

endmodule

//--- hdl/pipePkg.sv
package pipePkg;

    // ####################################################################
    // datapath sizing and internal control codes
    // ####################################################################
    localparam int regAddrW = 4;
    localparam int numRegs  = 15;  // R0 to R14, R15 is not stored

    // ALU control, carried from decode through deReg
    localparam logic [1:0] aluAdd = 2'b00;
    localparam logic [1:0] aluSub = 2'b01;
    localparam logic [1:0] aluAnd = 2'b10;
    localparam logic [1:0] aluOrr = 2'b11;

endpackage

//--- hdl/isaPkg.sv
package isaPkg;

    // ####################################################################
    // instruction word, one 32-bit word seen as data processing or memory
    // ####################################################################
    typedef union packed {
        struct packed {
            logic [3:0]  cond;
            logic [1:0]  op;
            logic        I;     // immediate second operand
            logic [3:0]  cmd;
            logic        S;     // set flags
            logic [3:0]  Rn;
            logic [3:0]  Rd;
            logic [11:0] src2;  // imm8, or shamt5/sh/0/Rm
        } dp;
        struct packed {
            logic [3:0]  cond;
            logic [1:0]  op;
            logic        notI;  // register offset, not handled here
            logic        P;
            logic        U;     // add offset when set, subtract otherwise
            logic        B;
            logic        W;
            logic        L;     // load when set, store otherwise
            logic [3:0]  Rn;
            logic [3:0]  Rd;
            logic [11:0] imm12;
        } mem;
    } instrWord_u;

    // condition field
    localparam logic [3:0] condEQ = 4'h0;
    localparam logic [3:0] condNE = 4'h1;
    localparam logic [3:0] condCS = 4'h2;
    localparam logic [3:0] condCC = 4'h3;
    localparam logic [3:0] condMI = 4'h4;
    localparam logic [3:0] condPL = 4'h5;
    localparam logic [3:0] condVS = 4'h6;
    localparam logic [3:0] condVC = 4'h7;
    localparam logic [3:0] condHI = 4'h8;
    localparam logic [3:0] condLS = 4'h9;
    localparam logic [3:0] condGE = 4'hA;
    localparam logic [3:0] condLT = 4'hB;
    localparam logic [3:0] condGT = 4'hC;
    localparam logic [3:0] condLE = 4'hD;
    localparam logic [3:0] condAL = 4'hE;

    localparam logic [1:0] opDataProc = 2'b00;
    localparam logic [1:0] opMemory   = 2'b01;

    localparam logic [3:0] cmdAnd = 4'b0000;
    localparam logic [3:0] cmdSub = 4'b0010;
    localparam logic [3:0] cmdAdd = 4'b0100;
    localparam logic [3:0] cmdCmp = 4'b1010;
    localparam logic [3:0] cmdOrr = 4'b1100;

    localparam logic [1:0] shLsl = 2'b00;
    localparam logic [1:0] shLsr = 2'b01;
    localparam logic [1:0] shAsr = 2'b10;
    localparam logic [1:0] shRor = 2'b11;

endpackage
